// ==== lc3b_macros.svh ====
`ifndef LC3B_MACROS_SVH
`define LC3B_MACROS_SVH

// ======================================================================
// datapath widths shared by every block of the decode stage
// ======================================================================

// data word and instruction word are the same size on the LC-3b
`define LC3B_WORD_W 16

// register ids index the eight general registers
`define LC3B_REG_W 3

`define LC3B_NUM_REGS 8

`endif

// ==== lc3b_isa_pkg.sv ====
`default_nettype none

`include "lc3b_macros.svh"

package lc3b_isa_pkg;

	// ======================================================================
	// opcodes, taken from ir[15:12]
	// ======================================================================

	localparam logic [3:0] OP_BR   = 4'b0000;
	localparam logic [3:0] OP_ADD  = 4'b0001;
	localparam logic [3:0] OP_LDB  = 4'b0010;
	localparam logic [3:0] OP_STB  = 4'b0011;
	localparam logic [3:0] OP_JSR  = 4'b0100; // also JSRR, told apart by ir[11]
	localparam logic [3:0] OP_AND  = 4'b0101;
	localparam logic [3:0] OP_LDR  = 4'b0110;
	localparam logic [3:0] OP_STR  = 4'b0111;
	localparam logic [3:0] OP_NOT  = 4'b1001;
	localparam logic [3:0] OP_LDI  = 4'b1010;
	localparam logic [3:0] OP_STI  = 4'b1011;
	localparam logic [3:0] OP_JMP  = 4'b1100; // RET is JMP through R7
	localparam logic [3:0] OP_SHF  = 4'b1101;
	localparam logic [3:0] OP_LEA  = 4'b1110;
	localparam logic [3:0] OP_TRAP = 4'b1111;

	// ======================================================================
	// instruction word, seen in register form or in immediate form
	// ======================================================================

	// bit 5 picks the form for ADD and AND, the rest only use one of them
	typedef union packed
	{
		struct packed
		{
			logic [3:0]             opcode;
			logic [`LC3B_REG_W-1:0] dr;
			logic [`LC3B_REG_W-1:0] sr1;
			logic                   imm;
			logic [1:0]             unused;
			logic [`LC3B_REG_W-1:0] sr2;
		} rf;

		struct packed
		{
			logic [3:0]             opcode;
			logic [`LC3B_REG_W-1:0] dr;
			logic [`LC3B_REG_W-1:0] sr1;
			logic                   imm;
			logic [4:0]             imm5;
		} im;
	} lc3b_instr;

endpackage : lc3b_isa_pkg

`default_nettype wire

// ==== lc3b_ctrl_pkg.sv ====
`default_nettype none

package lc3b_ctrl_pkg;

	// ======================================================================
	// ALU operation select, carried in the aluop control field
	// ======================================================================

	// address arithmetic for loads and stores also uses the adder
	localparam logic [2:0] ALU_ADD  = 3'd0;
	localparam logic [2:0] ALU_AND  = 3'd1;
	localparam logic [2:0] ALU_NOT  = 3'd2;
	localparam logic [2:0] ALU_SHF  = 3'd3; // direction and fill come from ir[5:4]

	// operand b goes straight through, used by LEA and the control transfers
	localparam logic [2:0] ALU_PASS = 3'd4;

	// ======================================================================
	// condition codes
	// ======================================================================

	// bit positions inside the 3-bit nzp field, matching BR's ir[11:9]
	localparam int CC_N = 2;
	localparam int CC_Z = 1;
	localparam int CC_P = 0;

endpackage : lc3b_ctrl_pkg

`default_nettype wire

// ==== control_rom.sv ====
`default_nettype none

module control_rom
	import lc3b_isa_pkg::*, lc3b_ctrl_pkg::*;
(
	input wire lc3b_instr ir,

	output logic [2:0] aluop,
	output logic       sr2_sel_dr,
	output logic       dest_r7,
	output logic       ld_reg,
	output logic       ld_cc,
	output logic       sr1_needed,
	output logic       sr2_needed,
	output logic       cc_needed,
	output logic       branch_stall,
	output logic       mem_read,
	output logic       mem_write
);

always_comb
begin
	aluop = ALU_PASS;
	sr2_sel_dr = 1'b0;
	dest_r7 = 1'b0;
	ld_reg = 1'b0;
	ld_cc = 1'b0;
	sr1_needed = 1'b0;
	sr2_needed = 1'b0;
	cc_needed = 1'b0;
	branch_stall = 1'b0;
	mem_read = 1'b0;
	mem_write = 1'b0;

	case (ir.rf.opcode)
		OP_ADD, OP_AND:
		begin
			aluop = (ir.rf.opcode == OP_ADD) ? ALU_ADD : ALU_AND;
			ld_reg = 1'b1;
			ld_cc = 1'b1;
			sr1_needed = 1'b1;
			sr2_needed = !ir.im.imm; // imm5 form has no second register
		end

		OP_NOT, OP_SHF:
		begin
			aluop = (ir.rf.opcode == OP_NOT) ? ALU_NOT : ALU_SHF;
			ld_reg = 1'b1;
			ld_cc = 1'b1;
			sr1_needed = 1'b1;
		end

		OP_LDR, OP_LDB, OP_LDI:
		begin
			aluop = ALU_ADD; // base plus offset
			ld_reg = 1'b1;
			ld_cc = 1'b1;
			sr1_needed = 1'b1;
			mem_read = 1'b1;
		end

		OP_STR, OP_STB, OP_STI:
		begin
			aluop = ALU_ADD;
			sr1_needed = 1'b1;
			sr2_needed = 1'b1;
			sr2_sel_dr = 1'b1; // store data sits in ir[11:9]
			mem_write = 1'b1;
			mem_read = (ir.rf.opcode == OP_STI); // STI fetches its pointer first
		end

		OP_LEA:
		begin
			ld_reg = 1'b1;
			ld_cc = 1'b1;
		end

		OP_BR:
		begin
			cc_needed = 1'b1;
			branch_stall = 1'b1;
		end

		OP_JMP:
		begin
			sr1_needed = 1'b1;
			branch_stall = 1'b1;
		end

		OP_JSR:
		begin
			ld_reg = 1'b1;
			dest_r7 = 1'b1;
			branch_stall = 1'b1;
			// ir[11] clear means JSRR, which jumps through the base register
			sr1_needed = !ir.rf.dr[2];
		end

		OP_TRAP:
		begin
			ld_reg = 1'b1;
			dest_r7 = 1'b1;
			branch_stall = 1'b1;
			mem_read = 1'b1; // trap vector table lookup
		end

		default:
		begin
			aluop = ALU_PASS; // RTI is not supported, it decodes to nothing
		end
	endcase

	// the all-zero word is a never-taken BR and must not touch anything
	if (ir == '0)
	begin
		aluop = '0;
		sr2_sel_dr = 1'b0;
		dest_r7 = 1'b0;
		ld_reg = 1'b0;
		ld_cc = 1'b0;
		sr1_needed = 1'b0;
		sr2_needed = 1'b0;
		cc_needed = 1'b0;
		branch_stall = 1'b0;
		mem_read = 1'b0;
		mem_write = 1'b0;
	end
end

endmodule : control_rom

`default_nettype wire

// ==== lc3b_regfile.sv ====
`default_nettype none

`include "lc3b_macros.svh"

module lc3b_regfile
	import lc3b_ctrl_pkg::*;
(
	input wire                    clk,
	input wire                    rst_n,

	input wire                    load,
	input wire [`LC3B_WORD_W-1:0] in,
	input wire [`LC3B_REG_W-1:0]  src_a,
	input wire [`LC3B_REG_W-1:0]  src_b,
	input wire [`LC3B_REG_W-1:0]  dest,

	input wire                    ld_cc,
	input wire [2:0]              cc_in,

	output logic [`LC3B_WORD_W-1:0] reg_a,
	output logic [`LC3B_WORD_W-1:0] reg_b,
	output logic [2:0]              cc_out
);

logic [`LC3B_WORD_W-1:0] regs [`LC3B_NUM_REGS];

// reads are combinational and a write in this cycle shows up next cycle
assign reg_a = regs[src_a];
assign reg_b = regs[src_b];

always_ff @(posedge clk)
begin
	if (!rst_n)
	begin
		for (int i = 0; i < `LC3B_NUM_REGS; i++)
			regs[i] <= '0;
		cc_out <= '0;
	end
	else
	begin
		if (load)
			regs[dest] <= in;
		if (ld_cc)
			cc_out <= cc_in; // nzp from the writeback result
	end
end

// ======================================================================
// checks
// ======================================================================

// writeback must always deliver a single flag
cc_one_hot: assert property (@(posedge clk) disable iff (!rst_n)
	ld_cc |-> (cc_in == (3'b001 << CC_N)) || (cc_in == (3'b001 << CC_Z))
		|| (cc_in == (3'b001 << CC_P)))
	else $error("nzp write %b is not one-hot", cc_in);

// a write through an unknown register id would corrupt the whole file
dest_known: assert property (@(posedge clk) disable iff (!rst_n)
	load |-> !$isunknown(dest))
	else $error("register write with an unknown destination id");

endmodule : lc3b_regfile

`default_nettype wire

// ==== hazard_unit.sv ====
`default_nettype none

`include "lc3b_macros.svh"

module hazard_unit
(
	input wire [`LC3B_REG_W-1:0] sr1_reg,
	input wire [`LC3B_REG_W-1:0] sr2_reg,
	input wire                   valid_in,

	input wire                   sr1_needed,
	input wire                   sr2_needed,
	input wire                   cc_needed,
	input wire                   branch_stall,

	input wire                   ex_ld_reg,
	input wire                   mem_ld_reg,
	input wire                   wb_ld_reg,
	input wire                   ex_ld_cc,
	input wire                   mem_ld_cc,
	input wire                   wb_ld_cc,
	input wire                   ex_valid,
	input wire                   mem_valid,
	input wire                   wb_valid,

	input wire [`LC3B_REG_W-1:0] ex_drid,
	input wire [`LC3B_REG_W-1:0] mem_drid,
	input wire [`LC3B_REG_W-1:0] wb_drid,

	input wire                   execute_br_stall,
	input wire                   execute_indirect_stall,
	input wire                   mem_stall,
	input wire                   mem_br_stall,
	input wire                   icache_stall,

	output logic                 dep_stall,
	output logic                 decode_br_stall,
	output logic                 valid,
	output logic                 load_ex
);

logic sr1_busy;
logic sr2_busy;
logic cc_busy;

// ======================================================================
// dependency check against execute, memory and writeback
// ======================================================================

// there is no forwarding, so even writeback's result is not yet readable
assign sr1_busy = (ex_valid && ex_ld_reg && (ex_drid == sr1_reg))
	|| (mem_valid && mem_ld_reg && (mem_drid == sr1_reg))
	|| (wb_valid && wb_ld_reg && (wb_drid == sr1_reg));

assign sr2_busy = (ex_valid && ex_ld_reg && (ex_drid == sr2_reg))
	|| (mem_valid && mem_ld_reg && (mem_drid == sr2_reg))
	|| (wb_valid && wb_ld_reg && (wb_drid == sr2_reg));

assign cc_busy = (ex_valid && ex_ld_cc) || (mem_valid && mem_ld_cc)
	|| (wb_valid && wb_ld_cc); // any pending nzp update blocks a BR

assign dep_stall = valid_in
	&& ((sr1_needed && sr1_busy) || (sr2_needed && sr2_busy) || (cc_needed && cc_busy));

// ======================================================================
// stall outputs
// ======================================================================

// fetch holds until the target is resolved further down
assign decode_br_stall = valid_in && branch_stall;

assign valid = valid_in
	&& !(dep_stall || execute_br_stall || mem_br_stall || icache_stall);

assign load_ex = !(mem_stall || execute_indirect_stall); // downstream is busy so the latch holds

endmodule : hazard_unit

`default_nettype wire

// ==== decode.sv ====
`default_nettype none

`include "lc3b_macros.svh"

module decode
	import lc3b_isa_pkg::*;
(
	input wire                     clk,
	input wire                     rst_n,
	input wire [`LC3B_WORD_W-1:0]  npc_in,
	input wire [`LC3B_WORD_W-1:0]  ir_in,
	input wire                     valid_in,

	// writeback
	input wire [`LC3B_WORD_W-1:0]  reg_data,
	input wire [`LC3B_REG_W-1:0]   dest_reg,
	input wire                     wb_ld_reg,
	input wire [2:0]               cc_data,
	input wire                     wb_ld_cc,

	// what is still in flight downstream
	input wire [`LC3B_REG_W-1:0]   ex_drid,
	input wire [`LC3B_REG_W-1:0]   mem_drid,
	input wire [`LC3B_REG_W-1:0]   wb_drid,
	input wire                     ex_ld_reg,
	input wire                     mem_ld_reg,
	input wire                     ex_ld_cc,
	input wire                     mem_ld_cc,
	input wire                     ex_valid,
	input wire                     mem_valid,
	input wire                     wb_valid,

	input wire                     execute_br_stall,
	input wire                     execute_indirect_stall,
	input wire                     mem_stall,
	input wire                     mem_br_stall,
	input wire                     icache_stall,

	output logic [`LC3B_WORD_W-1:0] npc,
	output logic [`LC3B_WORD_W-1:0] ir,
	output logic [`LC3B_WORD_W-1:0] sr1,
	output logic [`LC3B_WORD_W-1:0] sr2,
	output logic [2:0]              cc_out,
	output logic [`LC3B_REG_W-1:0]  dr,
	output logic [`LC3B_REG_W-1:0]  sr1_reg,
	output logic [`LC3B_REG_W-1:0]  sr2_reg,

	output logic [2:0]              aluop,
	output logic                    sr2_sel_dr,
	output logic                    dest_r7,
	output logic                    ld_reg,
	output logic                    ld_cc,
	output logic                    sr1_needed,
	output logic                    sr2_needed,
	output logic                    cc_needed,
	output logic                    branch_stall,
	output logic                    mem_read,
	output logic                    mem_write,

	output logic                    valid,
	output logic                    load_ex,
	output logic                    dep_stall,
	output logic                    decode_br_stall
);

lc3b_instr instr;

assign instr = ir_in;
assign npc = npc_in;
assign ir = ir_in;

// ======================================================================
// register id selection
// ======================================================================

assign sr1_reg = instr.rf.sr1;
assign sr2_reg = sr2_sel_dr ? instr.rf.dr : instr.rf.sr2; // stores read their data from dr

// JSR and TRAP link into the last register
assign dr = dest_r7 ? `LC3B_REG_W'(`LC3B_NUM_REGS - 1) : instr.rf.dr;

control_rom control_store
(
	.ir(instr),
	.aluop,
	.sr2_sel_dr,
	.dest_r7,
	.ld_reg,
	.ld_cc,
	.sr1_needed,
	.sr2_needed,
	.cc_needed,
	.branch_stall,
	.mem_read,
	.mem_write
);

lc3b_regfile regfile
(
	.clk,
	.rst_n,
	.load(wb_ld_reg),
	.in(reg_data),
	.src_a(sr1_reg),
	.src_b(sr2_reg),
	.dest(dest_reg),
	.ld_cc(wb_ld_cc),
	.cc_in(cc_data),
	.reg_a(sr1),
	.reg_b(sr2),
	.cc_out
);

hazard_unit hazards
(
	.sr1_reg,
	.sr2_reg,
	.valid_in,
	.sr1_needed,
	.sr2_needed,
	.cc_needed,
	.branch_stall,
	.ex_ld_reg,
	.mem_ld_reg,
	.wb_ld_reg,
	.ex_ld_cc,
	.mem_ld_cc,
	.wb_ld_cc,
	.ex_valid,
	.mem_valid,
	.wb_valid,
	.ex_drid,
	.mem_drid,
	.wb_drid,
	.execute_br_stall,
	.execute_indirect_stall,
	.mem_stall,
	.mem_br_stall,
	.icache_stall,
	.dep_stall,
	.decode_br_stall,
	.valid,
	.load_ex
);

endmodule : decode

`default_nettype wire

// ==== decode_checker.sv ====
`default_nettype none

`include "lc3b_macros.svh"

module decode_checker
	import lc3b_isa_pkg::*, lc3b_ctrl_pkg::*;
(
	input wire                    clk,
	input wire                    rst_n,
	input wire [2:0]              test_idx,

	// stimulus as the DUT sees it
	input wire [`LC3B_WORD_W-1:0] npc_in, ir_in, reg_data,
	input wire [`LC3B_REG_W-1:0]  dest_reg, ex_drid, mem_drid, wb_drid,
	input wire [2:0]              cc_data,
	input wire                    valid_in, wb_ld_reg, wb_ld_cc,
	input wire                    ex_ld_reg, mem_ld_reg, ex_ld_cc, mem_ld_cc,
	input wire                    ex_valid, mem_valid, wb_valid,
	input wire                    execute_br_stall, execute_indirect_stall,
	input wire                    mem_stall, mem_br_stall, icache_stall,

	// DUT responses
	input wire [`LC3B_WORD_W-1:0] npc, ir, sr1, sr2,
	input wire [`LC3B_REG_W-1:0]  dr, sr1_reg, sr2_reg,
	input wire [2:0]              cc_out, aluop,
	input wire                    sr2_sel_dr, dest_r7, ld_reg, ld_cc,
	input wire                    sr1_needed, sr2_needed, cc_needed,
	input wire                    branch_stall, mem_read, mem_write,
	input wire                    valid, load_ex, dep_stall, decode_br_stall
);

logic [`LC3B_WORD_W-1:0] model_regs [`LC3B_NUM_REGS];
logic [2:0] model_cc;
logic primed = 1'b0; // no register state exists before the first edge
int errors [5];
int checked [5];

initial
begin
	for (int i = 0; i < 5; i++)
	begin
		errors[i] = 0;
		checked[i] = 0;
	end
end

// ======================================================================
// reference model
// ======================================================================

// field order {aluop, sr2_sel_dr, dest_r7, ld_reg, ld_cc, sr1, sr2, cc, br, rd, wr}
function automatic logic [12:0] expected_ctrl(input logic [`LC3B_WORD_W-1:0] w);
	logic [12:0] f;
	case (w[15:12])
		OP_ADD:  f = {ALU_ADD, 10'b0011110000};
		OP_AND:  f = {ALU_AND, 10'b0011110000};
		OP_NOT:  f = {ALU_NOT, 10'b0011100000};
		OP_SHF:  f = {ALU_SHF, 10'b0011100000};
		OP_LDR, OP_LDB, OP_LDI: f = {ALU_ADD, 10'b0011100010};
		OP_STR, OP_STB: f = {ALU_ADD, 10'b1000110001};
		OP_STI:  f = {ALU_ADD, 10'b1000110011};
		OP_LEA:  f = {ALU_PASS, 10'b0011000000};
		OP_BR:   f = {ALU_PASS, 10'b0000001100};
		OP_JMP:  f = {ALU_PASS, 10'b0000100100};
		OP_JSR:  f = {ALU_PASS, 10'b0110000100};
		OP_TRAP: f = {ALU_PASS, 10'b0110000110};
		default: f = {ALU_PASS, 10'b0000000000};
	endcase
	if (w[15:12] == OP_ADD || w[15:12] == OP_AND)
		f[4] = !w[5]; // immediate form reads one register
	if (w[15:12] == OP_JSR)
		f[5] = !w[11];
	if (w == '0)
		f = '0;
	return f;
endfunction

function automatic logic reg_in_flight(input logic [`LC3B_REG_W-1:0] id);
	return (ex_valid && ex_ld_reg && ex_drid == id)
		|| (mem_valid && mem_ld_reg && mem_drid == id)
		|| (wb_valid && wb_ld_reg && wb_drid == id);
endfunction

task automatic compare_field(input string name, input logic [15:0] got,
	input logic [15:0] exp);
	if (got !== exp)
	begin
		errors[test_idx] = errors[test_idx] + 1;
		$display("MISMATCH %s dut=%h model=%h at time %0t", name, got, exp, $time);
	end
endtask

task automatic check_outputs();
	logic [12:0] f;
	logic [`LC3B_REG_W-1:0] exp_sr2_reg;
	logic [`LC3B_REG_W-1:0] exp_dr;
	logic cc_pending;
	logic exp_dep;
	f = expected_ctrl(ir_in);
	exp_sr2_reg = f[9] ? ir_in[11:9] : ir_in[2:0];
	exp_dr = f[8] ? 3'd7 : ir_in[11:9];
	cc_pending = (ex_valid && ex_ld_cc) || (mem_valid && mem_ld_cc) || (wb_valid && wb_ld_cc);
	exp_dep = valid_in && ((f[5] && reg_in_flight(ir_in[8:6]))
		|| (f[4] && reg_in_flight(exp_sr2_reg)) || (f[3] && cc_pending));
	checked[test_idx] = checked[test_idx] + 1;
	compare_field("aluop", aluop, f[12:10]);
	compare_field("sr2_sel_dr", sr2_sel_dr, f[9]);
	compare_field("dest_r7", dest_r7, f[8]);
	compare_field("ld_reg", ld_reg, f[7]);
	compare_field("ld_cc", ld_cc, f[6]);
	compare_field("sr1_needed", sr1_needed, f[5]);
	compare_field("sr2_needed", sr2_needed, f[4]);
	compare_field("cc_needed", cc_needed, f[3]);
	compare_field("branch_stall", branch_stall, f[2]);
	compare_field("mem_read", mem_read, f[1]);
	compare_field("mem_write", mem_write, f[0]);
	compare_field("npc", npc, npc_in);
	compare_field("ir", ir, ir_in);
	compare_field("sr1_reg", sr1_reg, ir_in[8:6]);
	compare_field("sr2_reg", sr2_reg, exp_sr2_reg);
	compare_field("dr", dr, exp_dr);
	compare_field("sr1", sr1, model_regs[ir_in[8:6]]);
	compare_field("sr2", sr2, model_regs[exp_sr2_reg]);
	compare_field("cc_out", cc_out, model_cc);
	compare_field("dep_stall", dep_stall, exp_dep);
	compare_field("decode_br_stall", decode_br_stall, valid_in && f[2]);
	compare_field("valid", valid, valid_in && !exp_dep && !execute_br_stall
		&& !mem_br_stall && !icache_stall);
	compare_field("load_ex", load_ex, !(mem_stall || execute_indirect_stall));
endtask

// writes land on the edge, so the new value is read from the next cycle
always @(posedge clk)
begin
	primed <= 1'b1;
	if (!rst_n)
	begin
		for (int i = 0; i < `LC3B_NUM_REGS; i++)
			model_regs[i] <= '0;
		model_cc <= '0;
	end
	else
	begin
		if (wb_ld_reg)
			model_regs[dest_reg] <= reg_data;
		if (wb_ld_cc)
			model_cc <= cc_data;
	end
end

always @(negedge clk)
begin
	if (primed)
		check_outputs(); // halfway between drive edges everything has settled
end

endmodule : decode_checker

`default_nettype wire

// ==== tb_decode.sv ====
`default_nettype none

`include "lc3b_macros.svh"

module tb_decode
	import lc3b_isa_pkg::*;
();

localparam int PERIOD = 20;
localparam int RESET_CYCLES = 10;
localparam int NUM_TESTS = 5;
localparam int TEST_CYCLES = 400;
// a fifth on top of the test cycles leaves room for reset and the mid-run reset pulse
localparam int WATCHDOG_CYCLES = NUM_TESTS * TEST_CYCLES * 6 / 5;

logic clk;
logic rst_n;
logic [2:0] test_idx;

logic [`LC3B_WORD_W-1:0] npc_in, ir_in, reg_data;
logic [`LC3B_REG_W-1:0] dest_reg, ex_drid, mem_drid, wb_drid;
logic [2:0] cc_data;
logic valid_in, wb_ld_reg, wb_ld_cc;
logic ex_ld_reg, mem_ld_reg, ex_ld_cc, mem_ld_cc, ex_valid, mem_valid, wb_valid;
logic execute_br_stall, execute_indirect_stall, mem_stall, mem_br_stall, icache_stall;

logic [`LC3B_WORD_W-1:0] npc, ir, sr1, sr2;
logic [`LC3B_REG_W-1:0] dr, sr1_reg, sr2_reg;
logic [2:0] cc_out, aluop;
logic sr2_sel_dr, dest_r7, ld_reg, ld_cc, sr1_needed, sr2_needed, cc_needed;
logic branch_stall, mem_read, mem_write;
logic valid, load_ex, dep_stall, decode_br_stall;

logic [31:0] rng_state;
int total_errors;
int failed_tests;

decode dut (.*);

decode_checker chk (.*);

function automatic logic [31:0] xorshift32(input logic [31:0] x);
	logic [31:0] y;
	y = x ^ (x << 13);
	y = y ^ (y >> 17);
	y = y ^ (y << 5);
	return y;
endfunction

function automatic logic [31:0] draw();
	rng_state = xorshift32(rng_state);
	return rng_state;
endfunction

function automatic string test_name(input int t);
	case (t)
		0: return "control decode";
		1: return "register select and read";
		2: return "dependency stall";
		3: return "branch and bubble";
		default: return "back-pressure and reset";
	endcase
endfunction

// ======================================================================
// stimulus, each test turns on one more part of the pipeline context
// ======================================================================

task automatic drive_cycle(input int t, input int n);
	logic [31:0] a;
	logic [31:0] b;
	logic [31:0] c;
	logic [31:0] d;
	logic [`LC3B_WORD_W-1:0] word;
	a = draw();
	b = draw();
	c = draw();
	d = draw();
	word = b[15:0];
	if (a[2:0] == 3'd0)
		word = '0;
	else if (t == 2 && a[3])
		word[15:12] = OP_BR; // lean on condition-code dependencies
	rst_n <= !(t == 4 && n >= TEST_CYCLES / 2 && n < TEST_CYCLES / 2 + 3);
	npc_in <= b[31:16];
	ir_in <= word;
	valid_in <= a[4] || a[5];
	wb_ld_reg <= (t >= 1) && a[6];
	wb_ld_cc <= (t >= 1) && a[7];
	reg_data <= c[15:0];
	dest_reg <= c[18:16];
	cc_data <= 3'b001 << (c[20:19] % 3); // writeback only ever sends one flag
	ex_drid <= d[2:0];
	mem_drid <= d[5:3];
	wb_drid <= d[8:6];
	ex_ld_reg <= d[9];
	mem_ld_reg <= d[10];
	ex_ld_cc <= d[11];
	mem_ld_cc <= d[12];
	ex_valid <= (t >= 2) && d[13];
	mem_valid <= (t >= 2) && d[14];
	wb_valid <= (t >= 2) && d[15];
	execute_br_stall <= (t >= 3) && d[16] && d[17];
	mem_br_stall <= (t >= 3) && d[18] && d[19];
	icache_stall <= (t >= 3) && d[20] && d[21];
	mem_stall <= (t == 4) && d[22];
	execute_indirect_stall <= (t == 4) && d[23];
endtask

initial
begin
	clk = 1'b0;
	forever #(PERIOD / 2) clk = ~clk;
end

initial
begin
	#(WATCHDOG_CYCLES * PERIOD);
	$display("timeout: the run did not finish within %0d cycles", WATCHDOG_CYCLES);
	$display("SIMULATION FAILED");
	$finish;
end

initial
begin
	rng_state = 32'd69;
	total_errors = 0;
	failed_tests = 0;
	rst_n = 1'b0;
	test_idx = '0;
	{npc_in, ir_in, reg_data, dest_reg, cc_data, valid_in, wb_ld_reg, wb_ld_cc} = '0;
	{ex_drid, mem_drid, wb_drid, ex_ld_reg, mem_ld_reg, ex_ld_cc, mem_ld_cc} = '0;
	{ex_valid, mem_valid, wb_valid} = '0;
	{execute_br_stall, execute_indirect_stall, mem_stall, mem_br_stall, icache_stall} = '0;
	repeat (RESET_CYCLES) @(posedge clk);

	for (int t = 0; t < NUM_TESTS; t++)
	begin
		for (int n = 0; n < TEST_CYCLES; n++)
		begin
			test_idx <= 3'(t);
			drive_cycle(t, n);
			@(posedge clk);
		end
		total_errors += chk.errors[t];
		if (chk.errors[t] == 0)
			$display("test %0d %s: passed, %0d cycles checked", t + 1, test_name(t),
				chk.checked[t]);
		else
		begin
			failed_tests++;
			$display("test %0d %s: failed with %0d mismatches", t + 1, test_name(t),
				chk.errors[t]);
		end
	end

	$display("totals: %0d tests, %0d failed, %0d mismatches", NUM_TESTS, failed_tests,
		total_errors);
	if (total_errors == 0)
		$display("SIMULATION PASSED");
	else
		$display("SIMULATION FAILED");
	$finish;
end

endmodule : tb_decode

`default_nettype wire

// ==== project.f ====
+incdir+.
lc3b_isa_pkg.sv
lc3b_ctrl_pkg.sv
control_rom.sv
lc3b_regfile.sv
hazard_unit.sv
decode.sv
decode_checker.sv
tb_decode.sv
